// ==== verilog/vtx_pkg.sv ====
package vtx_pkg;

	// ==================================================
	// frame and segment geometry
	// ==================================================
	localparam int FRAME_PIXELS = 64;
	localparam int PIX_AW       = 6;    // pixel address width
	localparam int SEG_COUNT    = 4;
	localparam int SEG_PIXELS   = 16;   // FRAME_PIXELS / SEG_COUNT
	localparam int SEG_BYTES    = 48;   // three colour bytes per pixel
	localparam int BYTE_AW      = 6;

	// ==================================================
	// transmit tagging and pipeline depth
	// ==================================================
	localparam int REDUNDANCY   = 3;    // copies per segment
	localparam int TXID_W       = 8;
	localparam int SEG_W        = 2;
	localparam int MEM_LATENCY  = 3;    // request to tx_data

	// one pixel word, seen as colours on capture and as byte lanes on transmit
	// lane 0 = r, lane 1 = b, lane 2 = g
	typedef union packed {
		struct packed {
			logic [7:0] g;
			logic [7:0] b;
			logic [7:0] r;
		} colour;
		logic [2:0][7:0] lane;
	} pixel_t;

endpackage

// ==== verilog/vtx_rd_if.sv ====
`timescale 1ns/1ps

interface vtx_rd_if;
	import vtx_pkg::*;

	logic [BYTE_AW-1:0] byte_idx;     // byte within the segment
	logic [TXID_W-1:0]  txid;
	logic [SEG_W-1:0]   seg;
	logic               active;       // request valid every cycle while high
	logic               frame_start;  // one cycle, at send

	modport seq (
		output byte_idx,
		output txid,
		output seg,
		output active,
		output frame_start
	);

	modport mem (
		input byte_idx,
		input txid,
		input seg,
		input active,
		input frame_start
	);

endinterface

// ==== verilog/pixel_capture.sv ====
`timescale 1ns/1ps

module pixel_capture (
	input  logic                       pclk,
	input  logic                       rst_n,
	input  logic                       pix_de,
	input  logic                       pix_vsync,
	input  logic [7:0]                 pix_r,
	input  logic [7:0]                 pix_g,
	input  logic [7:0]                 pix_b,
	output logic                       wr_en,
	output logic [vtx_pkg::PIX_AW-1:0] wr_addr,
	output vtx_pkg::pixel_t            wr_pixel
);
	import vtx_pkg::*;

	logic [PIX_AW-1:0] addr;

	// pack colours into one word
	always_comb begin
		wr_pixel.colour.r = pix_r;
		wr_pixel.colour.g = pix_g;
		wr_pixel.colour.b = pix_b;
	end

	assign wr_en   = pix_de;  // write lands at current address
	assign wr_addr = addr;

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			addr <= '0;
		end else if (pix_vsync) begin
			addr <= '0;  // new frame
		end else if (pix_de) begin
			addr <= (addr == PIX_AW'(FRAME_PIXELS - 1)) ? '0 : addr + 1'b1;
		end
	end

endmodule

// ==== verilog/frame_ram.sv ====
`timescale 1ns/1ps

module frame_ram (
	input  logic                       wr_clk,
	input  logic                       wr_en,
	input  logic [vtx_pkg::PIX_AW-1:0] wr_addr,
	input  vtx_pkg::pixel_t            wr_pixel,
	input  logic                       rd_clk,
	input  logic [vtx_pkg::PIX_AW-1:0] rd_addr,
	output vtx_pkg::pixel_t            rd_pixel
);
	import vtx_pkg::*;

	pixel_t mem [FRAME_PIXELS];

	// pixel clock side
	always_ff @(posedge wr_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_pixel;
		end
	end

	// ethernet side, one cycle read
	always_ff @(posedge rd_clk) begin
		rd_pixel <= mem[rd_addr];
	end

endmodule

// ==== verilog/segment_buffer.sv ====
`timescale 1ns/1ps

module segment_buffer (
	input  logic                        clk125MHz,
	input  logic                        we,
	input  logic [vtx_pkg::BYTE_AW-1:0] waddr,
	input  logic [7:0]                  wdata,
	input  logic [vtx_pkg::BYTE_AW-1:0] raddr,
	output logic [7:0]                  rdata
);
	import vtx_pkg::*;

	logic [7:0] mem [SEG_BYTES];  // bytes of the first copy

	always_ff @(posedge clk125MHz) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

// ==== verilog/tx_memory_control.sv ====
`timescale 1ns/1ps

module tx_memory_control (
	input  logic                       clk125MHz,
	input  logic                       rst_n,
	vtx_rd_if.mem                      rd,
	output logic [vtx_pkg::PIX_AW-1:0] ram_addr,
	input  vtx_pkg::pixel_t            ram_pixel,
	output logic [7:0]                 tx_data
);
	import vtx_pkg::*;

	logic [PIX_AW-1:0]    startaddr;  // first pixel of current segment
	logic [1:0]           lane_d1;
	logic                 active_d1;
	logic                 active_d2;
	logic [TXID_W-1:0]    txid_d1;
	logic [TXID_W-1:0]    txid_d2;
	logic [SEG_W-1:0]     seg_d1;
	logic [SEG_W-1:0]     seg_d2;
	logic [BYTE_AW-1:0]   byte_idx_d1;
	logic [BYTE_AW-1:0]   byte_idx_d2;
	logic [7:0]           lane_q;     // fresh byte
	logic [7:0]           replay_q;   // buffered byte
	logic                 wr_active;
	logic [SEG_COUNT-1:0] buf_we;
	logic [7:0]           buf_rdata [SEG_COUNT];

	// ==================================================
	// segment start address
	// ==================================================
	always_ff @(posedge clk125MHz or negedge rst_n) begin
		if (!rst_n) begin
			startaddr <= '0;
		end else if (rd.frame_start) begin
			startaddr <= '0;
		end else if (active_d1 && !rd.active && rd.txid == TXID_W'(REDUNDANCY)) begin
			// last copy of the segment just ended
			startaddr <= startaddr + PIX_AW'(SEG_PIXELS);
		end
	end

	assign ram_addr = startaddr + PIX_AW'(rd.byte_idx / 6'd3);

	// ==================================================
	// request pipeline
	// ==================================================
	always_ff @(posedge clk125MHz or negedge rst_n) begin
		if (!rst_n) begin
			active_d1 <= 1'b0;
			active_d2 <= 1'b0;
		end else begin
			active_d1 <= rd.active;
			active_d2 <= active_d1;
		end
	end

	always_ff @(posedge clk125MHz) begin
		lane_d1     <= 2'(rd.byte_idx % 6'd3);
		txid_d1     <= rd.txid;
		txid_d2     <= txid_d1;
		seg_d1      <= rd.seg;
		seg_d2      <= seg_d1;
		byte_idx_d1 <= rd.byte_idx;
		byte_idx_d2 <= byte_idx_d1;
		lane_q      <= ram_pixel.lane[lane_d1];  // r, b, g order
		replay_q    <= buf_rdata[seg_d1];
		tx_data     <= (txid_d2 == TXID_W'(1)) ? lane_q : replay_q;
	end

	// first copy bytes go into the buffer as they leave lane select
	assign wr_active = active_d2 && (txid_d2 == TXID_W'(1));

	for (genvar s = 0; s < SEG_COUNT; s++) begin : g_seg
		assign buf_we[s] = wr_active && (seg_d2 == SEG_W'(s));

		segment_buffer i_segment_buffer (
			.clk125MHz (clk125MHz),
			.we        (buf_we[s]),
			.waddr     (byte_idx_d2),
			.wdata     (lane_q),
			.raddr     (rd.byte_idx),
			.rdata     (buf_rdata[s])
		);
	end

endmodule

// ==== verilog/tx_sequencer.sv ====
`timescale 1ns/1ps

module tx_sequencer (
	input  logic                       clk125MHz,
	input  logic                       rst_n,
	input  logic                       send,
	vtx_rd_if.seq                      rd,
	output logic                       tx_valid,
	output logic                       tx_first,
	output logic [vtx_pkg::TXID_W-1:0] tx_txid,
	output logic [vtx_pkg::SEG_W-1:0]  tx_seg,
	output logic                       busy
);
	import vtx_pkg::*;

	logic                   start;
	logic                   run;       // frame in progress
	logic                   active;
	logic [BYTE_AW-1:0]     byte_idx;
	logic [TXID_W-1:0]      txid;
	logic [SEG_W-1:0]       seg;
	logic [MEM_LATENCY-1:0] valid_sr;
	logic [MEM_LATENCY-1:0] first_sr;
	logic [TXID_W-1:0]      txid_sr [MEM_LATENCY];
	logic [SEG_W-1:0]       seg_sr [MEM_LATENCY];

	assign start = send && !busy;  // send while busy is dropped

	// ==================================================
	// segment / txid / byte loop
	// ==================================================
	always_ff @(posedge clk125MHz or negedge rst_n) begin
		if (!rst_n) begin
			run      <= 1'b0;
			active   <= 1'b0;
			byte_idx <= '0;
			txid     <= TXID_W'(1);
			seg      <= '0;
		end else if (start) begin
			run      <= 1'b1;
			active   <= 1'b1;
			byte_idx <= '0;
			txid     <= TXID_W'(1);
			seg      <= '0;
		end else if (active) begin
			if (byte_idx == BYTE_AW'(SEG_BYTES - 1)) begin
				active   <= 1'b0;  // idle gap follows
				byte_idx <= '0;
				if (txid == TXID_W'(REDUNDANCY) && seg == SEG_W'(SEG_COUNT - 1)) begin
					run <= 1'b0;
				end
			end else begin
				byte_idx <= byte_idx + 1'b1;
			end
		end else if (run) begin
			active <= 1'b1;
			if (txid == TXID_W'(REDUNDANCY)) begin
				txid <= TXID_W'(1);
				seg  <= seg + 1'b1;
			end else begin
				txid <= txid + 1'b1;
			end
		end
	end

	assign rd.active      = active;
	assign rd.byte_idx    = byte_idx;
	assign rd.txid        = txid;
	assign rd.seg         = seg;
	assign rd.frame_start = start;

	// align strobes with tx_data
	always_ff @(posedge clk125MHz or negedge rst_n) begin
		if (!rst_n) begin
			valid_sr <= '0;
			first_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[MEM_LATENCY-2:0], active};
			first_sr <= {first_sr[MEM_LATENCY-2:0], active && byte_idx == '0};
		end
	end

	always_ff @(posedge clk125MHz) begin
		txid_sr[0] <= txid;
		seg_sr[0]  <= seg;
		for (int i = 1; i < MEM_LATENCY; i++) begin
			txid_sr[i] <= txid_sr[i-1];
			seg_sr[i]  <= seg_sr[i-1];
		end
	end

	assign tx_valid = valid_sr[MEM_LATENCY-1];
	assign tx_first = first_sr[MEM_LATENCY-1];
	assign tx_txid  = txid_sr[MEM_LATENCY-1];
	assign tx_seg   = seg_sr[MEM_LATENCY-1];
	assign busy     = run || (|valid_sr);  // held until last strobe is out

endmodule

// ==== verilog/hdmi_eth_tx_top.sv ====
`timescale 1ns/1ps

module hdmi_eth_tx_top (
	input  logic                       pclk,
	input  logic                       pix_de,
	input  logic                       pix_vsync,
	input  logic [7:0]                 pix_r,
	input  logic [7:0]                 pix_g,
	input  logic [7:0]                 pix_b,
	input  logic                       clk125MHz,
	input  logic                       rst_n,
	input  logic                       send,
	output logic [7:0]                 tx_data,
	output logic                       tx_valid,
	output logic                       tx_first,
	output logic [vtx_pkg::TXID_W-1:0] tx_txid,
	output logic [vtx_pkg::SEG_W-1:0]  tx_seg,
	output logic                       busy
);
	import vtx_pkg::*;

	logic              wr_en;
	logic [PIX_AW-1:0] wr_addr;
	pixel_t            wr_pixel;
	logic [PIX_AW-1:0] ram_addr;
	pixel_t            ram_pixel;

	vtx_rd_if rd_bus ();

	// pixel clock domain
	pixel_capture i_pixel_capture (
		.pclk      (pclk),
		.rst_n     (rst_n),
		.pix_de    (pix_de),
		.pix_vsync (pix_vsync),
		.pix_r     (pix_r),
		.pix_g     (pix_g),
		.pix_b     (pix_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_pixel  (wr_pixel)
	);

	frame_ram i_frame_ram (
		.wr_clk   (pclk),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_pixel (wr_pixel),
		.rd_clk   (clk125MHz),
		.rd_addr  (ram_addr),
		.rd_pixel (ram_pixel)
	);

	// ethernet clock domain
	tx_sequencer i_tx_sequencer (
		.clk125MHz (clk125MHz),
		.rst_n     (rst_n),
		.send      (send),
		.rd        (rd_bus.seq),
		.tx_valid  (tx_valid),
		.tx_first  (tx_first),
		.tx_txid   (tx_txid),
		.tx_seg    (tx_seg),
		.busy      (busy)
	);

	tx_memory_control i_tx_memory_control (
		.clk125MHz (clk125MHz),
		.rst_n     (rst_n),
		.rd        (rd_bus.mem),
		.ram_addr  (ram_addr),
		.ram_pixel (ram_pixel),
		.tx_data   (tx_data)
	);

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk125MHz,
	output logic pclk,
	output logic rst_n
);

	initial begin
		clk125MHz = 1'b0;
		forever #4 clk125MHz = ~clk125MHz;  // 8 ns period
	end

	initial begin
		pclk = 1'b0;
		forever #7 pclk = ~pclk;  // 14 ns pixel clock
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk125MHz);
		#1 rst_n = 1'b1;
	end

endmodule

// ==== tests/tb_hdmi_eth_tx.sv ====
`timescale 1ns/1ps

module tb_hdmi_eth_tx;
	import vtx_pkg::*;

	logic              clk125MHz;
	logic              pclk;
	logic              rst_n;
	logic              pix_de;
	logic              pix_vsync;
	logic [7:0]        pix_r;
	logic [7:0]        pix_g;
	logic [7:0]        pix_b;
	logic              send;
	logic [7:0]        tx_data;
	logic              tx_valid;
	logic              tx_first;
	logic [TXID_W-1:0] tx_txid;
	logic [SEG_W-1:0]  tx_seg;
	logic              busy;
	logic [31:0]       lfsr;
	logic [7:0]        model_px [FRAME_PIXELS][3];  // what the frame memory holds, r g b
	logic [7:0]        exp_px [FRAME_PIXELS][3];    // frame the running stream must carry

	tb_clock i_tb_clock (.clk125MHz(clk125MHz), .pclk(pclk), .rst_n(rst_n));

	hdmi_eth_tx_top i_hdmi_eth_tx_top (
		.pclk(pclk), .pix_de(pix_de), .pix_vsync(pix_vsync),
		.pix_r(pix_r), .pix_g(pix_g), .pix_b(pix_b),
		.clk125MHz(clk125MHz), .rst_n(rst_n), .send(send),
		.tx_data(tx_data), .tx_valid(tx_valid), .tx_first(tx_first),
		.tx_txid(tx_txid), .tx_seg(tx_seg), .busy(busy)
	);

	// ==================================================
	// random source and reference model
	// ==================================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
		end
		return state >> 1;
	endfunction

	function logic [7:0] random_byte();
		logic [7:0] value;
		int         i;
		value = '0;
		for (i = 0; i < 8; i++) begin
			lfsr  = lfsr_next(lfsr);  // one step per bit
			value = {value[6:0], lfsr[0]};
		end
		return value;
	endfunction

	// byte b of segment s, lanes go r, b, g
	function automatic logic [7:0] expected_byte(input int s, input int b);
		int pix;
		pix = s * SEG_PIXELS + b / 3;
		case (b % 3)
			0: return exp_px[pix][0];
			1: return exp_px[pix][2];
			default: return exp_px[pix][1];
		endcase
	endfunction

	task take_snapshot();
		int i;
		for (i = 0; i < FRAME_PIXELS; i++) begin
			exp_px[i] = model_px[i];
		end
	endtask

	task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task stop_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("sim failed");
		$fatal(1, "wait timed out");
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	task write_pixels(input int count);
		int i;
		@(posedge pclk);
		#1;
		pix_vsync = 1'b1;  // back to address 0
		pix_de    = 1'b0;
		@(posedge pclk);
		#1;
		pix_vsync = 1'b0;
		for (i = 0; i < count; i++) begin
			pix_r          = random_byte();
			pix_g          = random_byte();
			pix_b          = random_byte();
			pix_de         = 1'b1;
			model_px[i][0] = pix_r;
			model_px[i][1] = pix_g;
			model_px[i][2] = pix_b;
			@(posedge pclk);
			#1;
		end
		pix_de = 1'b0;
	endtask

	task pulse_send();
		@(posedge clk125MHz);
		#1 send = 1'b1;
		@(posedge clk125MHz);
		#1 send = 1'b0;
	endtask

	task wait_for_valid(input string what);
		int n;
		n = 0;
		while (tx_valid !== 1'b1) begin
			@(negedge clk125MHz);
			n++;
			if (n > 20) stop_on_timeout(what);
		end
	endtask

	task wait_for_idle();
		int n;
		n = 0;
		while (busy !== 1'b0) begin
			@(negedge clk125MHz);
			check_value("tx_valid", 32'(tx_valid), 32'd0);
			n++;
			if (n > 20) stop_on_timeout("busy to fall");
		end
	endtask

	// sends one frame and checks every byte of every copy
	task stream_frame();
		int cycles;
		int s;
		int t;
		int b;
		pulse_send();
		@(negedge clk125MHz);
		check_value("busy", 32'(busy), 32'd1);
		cycles = 1;
		while (tx_valid !== 1'b1) begin
			@(negedge clk125MHz);
			cycles++;
			if (cycles > 50) stop_on_timeout("first tx_valid after send");
		end
		check_value("send to tx_valid cycles", cycles, MEM_LATENCY + 1);
		for (s = 0; s < SEG_COUNT; s++) begin
			for (t = 1; t <= REDUNDANCY; t++) begin
				if (s != 0 || t != 1) begin
					@(negedge clk125MHz);
					check_value("tx_valid", 32'(tx_valid), 32'd0);  // idle gap
					wait_for_valid("next copy");
				end
				for (b = 0; b < SEG_BYTES; b++) begin
					if (b != 0) @(negedge clk125MHz);
					check_value("tx_valid", 32'(tx_valid), 32'd1);
					check_value("tx_first", 32'(tx_first), 32'(b == 0));
					check_value("tx_txid", 32'(tx_txid), t);
					check_value("tx_seg", 32'(tx_seg), s);
					check_value("tx_data", 32'(tx_data), 32'(expected_byte(s, b)));
				end
			end
		end
		wait_for_idle();
	endtask

	// new pixels land once a segment's first copy is out
	task rewrite_during_stream();
		int s;
		int n;
		for (s = 0; s < SEG_COUNT; s++) begin
			n = 0;
			@(negedge clk125MHz);
			while (!(tx_valid === 1'b1 && tx_first === 1'b1 &&
					tx_txid == TXID_W'(2) && tx_seg == SEG_W'(s))) begin
				@(negedge clk125MHz);
				n++;
				if (n > 1000) stop_on_timeout("second copy of a segment");
			end
			write_pixels((s + 1) * SEG_PIXELS);
			if (s == 1) begin
				pulse_send();  // busy, must be dropped
			end
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		int i;
		int n;
		lfsr        = 32'h9460;
		send        = 1'b0;
		pix_de      = 1'b0;
		pix_vsync   = 1'b0;
		pix_r       = 8'h00;
		pix_g       = 8'h00;
		pix_b       = 8'h00;
		n = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk125MHz);
			n++;
			if (n > 20) stop_on_timeout("reset release");
		end
		for (i = 0; i < 20; i++) begin
			@(negedge clk125MHz);
			check_value("tx_valid", 32'(tx_valid), 32'd0);
			check_value("tx_first", 32'(tx_first), 32'd0);
			check_value("busy", 32'(busy), 32'd0);
		end
		write_pixels(FRAME_PIXELS);
		take_snapshot();
		fork
			stream_frame();
			rewrite_during_stream();
		join
		for (i = 0; i < 10; i++) begin
			@(negedge clk125MHz);
			check_value("tx_valid", 32'(tx_valid), 32'd0);
			check_value("busy", 32'(busy), 32'd0);
		end
		take_snapshot();  // second send carries the rewritten frame
		stream_frame();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== build.f ====
verilog/vtx_pkg.sv
verilog/vtx_rd_if.sv
verilog/pixel_capture.sv
verilog/frame_ram.sv
verilog/segment_buffer.sv
verilog/tx_memory_control.sv
verilog/tx_sequencer.sv
verilog/hdmi_eth_tx_top.sv
tests/tb_clock.sv
tests/tb_hdmi_eth_tx.sv

// ==== Makefile ====
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f build.f \
		--top-module tb_hdmi_eth_tx -Mdir $(OBJ_DIR) -o vsim
	./$(OBJ_DIR)/vsim | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
